// ==== common/nn_ctrl_macros.svh ====
`ifndef NN_CTRL_MACROS_SVH
`define NN_CTRL_MACROS_SVH

// Layer geometry of the input layer
`define NN_P 32 // Neurons in the layer
`define NN_FO 2 // Fan-out of each neuron
`define NN_Z 8 // Memories read and written in parallel
`define NN_L 3 // Layers in the network
`define NN_WIDTH 8 // Bits of one activation

// One junction cycle is P*FO/Z working clocks plus two clocks of pipeline slack
`define NN_CPC ((`NN_P * `NN_FO / `NN_Z) + 2)
`define NN_COLL ((2 * `NN_L) - 1) // Activation collections kept in rotation
`define NN_WORK (`NN_CPC - 2) // Clocks per cycle that move real data

// Derived field widths
`define NN_IDX_W $clog2(`NN_CPC) // Cycle index
`define NN_NIDX_W $clog2(`NN_P) // Interleaved neuron index
`define NN_AM_AW $clog2(`NN_P / `NN_Z) // Entries in one activation memory
`define NN_SEL_W $clog2(`NN_Z) // Selects one of the Z lanes
`define NN_WM_AW $clog2(`NN_WORK) // Entries in one weight memory
`define NN_PART_W $clog2(`NN_FO) // Selects one of the FO parts

`endif

// ==== common/nn_ctrl_pkg.sv ====
`include "nn_ctrl_macros.svh"

package nn_ctrl_pkg;

	// Position inside the current junction cycle
	typedef logic [`NN_IDX_W-1:0] cycle_idx_t;

	// Points at one of the 2L-1 activation collections
	typedef logic [$clog2(`NN_COLL)-1:0] coll_pt_t;

	// One neuron index as it leaves the interleaver
	// Low bits name the memory, high bits name the entry inside it
	typedef logic [`NN_NIDX_W-1:0] neuron_idx_t;

	typedef logic [`NN_AM_AW-1:0] am_addr_t; // Entry inside one activation memory
	typedef logic [`NN_SEL_W-1:0] lane_sel_t; // One of the Z lanes or memories
	typedef logic [`NN_WM_AW-1:0] wm_addr_t; // Entry inside one weight memory

	// Everything the downstream logic needs to know about time
	typedef struct packed
	{
		cycle_idx_t idx; // Current clock within the junction cycle
		cycle_idx_t idx_d2; // Same index two clocks late, used for writing
		logic wrap; // High in the last clock of the junction cycle
	} timing_s;

	// Collection roles, all stepping together at every wrap
	typedef struct packed
	{
		coll_pt_t rff; // Read for feed-forward of the next layer
		coll_pt_t wr; // Written by the previous layer
		coll_pt_t rup; // Read for the weight update
	} pointer_s;

	// Output of the address decoder
	typedef struct packed
	{
		am_addr_t [`NN_Z-1:0] rd_addr; // Entry that memory j must read
		lane_sel_t [`NN_Z-1:0] mux_sel; // Memory that lane j takes its value from
	} decode_s;

	// Control of one activation collection
	typedef struct packed
	{
		logic [`NN_Z-1:0] we; // One enable per memory
		am_addr_t [`NN_Z-1:0] addr; // One address per memory
	} am_ctrl_s;

	// Weight memories share one address, so it is given only once
	// Port A only reads and needs no enable here
	typedef struct packed
	{
		logic we_b; // Port B write enable
		wm_addr_t rd_addr; // Port A read address
		wm_addr_t wr_addr; // Port B write address, one clock behind the read
	} wm_ctrl_s;

endpackage

// ==== rtl/cycle_timer.sv ====
`include "nn_ctrl_macros.svh"

module cycle_timer
(
	input logic clk,
	input logic reset_i,
	output nn_ctrl_pkg::timing_s timing_o
);

	nn_ctrl_pkg::cycle_idx_t idx_q; // Free-running index within a junction cycle
	nn_ctrl_pkg::cycle_idx_t idx_d1_q; // First stage of the write delay
	nn_ctrl_pkg::cycle_idx_t idx_d2_q; // Second stage, what the write side uses
	logic wrap;

	// Last clock of the junction cycle
	assign wrap = (idx_q == nn_ctrl_pkg::cycle_idx_t'(`NN_CPC - 1));

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			idx_q <= '0;
			idx_d1_q <= '0; // Both delay stages read 0 for two clocks after reset
			idx_d2_q <= '0;
		end
		else
		begin
			idx_q <= wrap ? '0 : idx_q + 1'b1; // Back to 0 after CPC-1
			idx_d1_q <= idx_q;
			idx_d2_q <= idx_d1_q;
		end
	end

	assign timing_o = '{idx: idx_q, idx_d2: idx_d2_q, wrap: wrap};

endmodule

// ==== rtl/input_layer_state_machine.sv ====
`include "nn_ctrl_macros.svh"

module input_layer_state_machine
(
	input logic clk,
	input logic reset_i,
	input nn_ctrl_pkg::timing_s timing_i,
	output nn_ctrl_pkg::pointer_s pointers_o, // Roles as they stand in this clock
	output nn_ctrl_pkg::coll_pt_t rff_pt_o, // Feed-forward read, aligned with the memory output
	output nn_ctrl_pkg::coll_pt_t rup_pt_o, // Update read, aligned with the memory output
	output nn_ctrl_pkg::wm_ctrl_s wm_ctrl_o
);

	nn_ctrl_pkg::pointer_s pt_q;
	nn_ctrl_pkg::coll_pt_t rff_pt_q;
	nn_ctrl_pkg::coll_pt_t rup_pt_q;
	nn_ctrl_pkg::wm_addr_t wm_rd_addr;
	nn_ctrl_pkg::wm_addr_t wm_wr_addr_q;
	logic wm_we_b;
	logic in_work; // Index lies in the working clocks 1..WORK

	// Next collection in the rotation
	function automatic nn_ctrl_pkg::coll_pt_t step_pt(input nn_ctrl_pkg::coll_pt_t pt);
		if (pt == nn_ctrl_pkg::coll_pt_t'(`NN_COLL - 1))
		begin
			return '0;
		end
		return pt + 1'b1;
	endfunction

	// The three roles rotate in lockstep, so they never collide
	// A collection is written first, then read for feed-forward, then for update
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			pt_q.rff <= nn_ctrl_pkg::coll_pt_t'(0);
			pt_q.wr <= nn_ctrl_pkg::coll_pt_t'(1);
			pt_q.rup <= nn_ctrl_pkg::coll_pt_t'(2);
		end
		else if (timing_i.wrap) // Roles change at the junction-cycle boundary only
		begin
			pt_q.rff <= step_pt(pt_q.rff);
			pt_q.wr <= step_pt(pt_q.wr);
			pt_q.rup <= step_pt(pt_q.rup);
		end
	end

	assign pointers_o = pt_q;

	// Read pointers go to the output muxes, which see data one clock after the address
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			rff_pt_q <= '0;
			rup_pt_q <= '0;
		end
		else
		begin
			rff_pt_q <= pt_q.rff;
			rup_pt_q <= pt_q.rup;
		end
	end

	assign rff_pt_o = rff_pt_q;
	assign rup_pt_o = rup_pt_q;

	// Every weight memory reads the same entry, indexed by the clock in the cycle
	assign wm_rd_addr = timing_i.idx[`NN_WM_AW-1:0];

	// Clock 0 only reads, so port B starts writing at clock 1
	assign in_work = (timing_i.idx != '0)
		&& (timing_i.idx <= nn_ctrl_pkg::cycle_idx_t'(`NN_WORK));
	assign wm_we_b = in_work && !reset_i;

	// The updated weight goes back to the entry read on the previous clock
	always_ff @(posedge clk)
	begin
		if (reset_i)
			wm_wr_addr_q <= '0;
		else
			wm_wr_addr_q <= wm_rd_addr;
	end

	assign wm_ctrl_o = '{we_b: wm_we_b, rd_addr: wm_rd_addr, wr_addr: wm_wr_addr_q};

endmodule

// ==== address_decoder/comparator_set.sv ====
`include "nn_ctrl_macros.svh"

module comparator_set #(
	parameter int MEM_ID = 0 // Memory that this search serves
)
(
	input nn_ctrl_pkg::neuron_idx_t [`NN_Z-1:0] neuron_idx_i,
	output nn_ctrl_pkg::lane_sel_t insert_o // Lane whose neuron sits in memory MEM_ID
);

	// Memory number in the same width as the low index bits
	localparam nn_ctrl_pkg::lane_sel_t MEM_SEL = nn_ctrl_pkg::lane_sel_t'(MEM_ID);

	// Plain priority scan over all lanes
	always_comb
	begin
		insert_o = '0; // Nobody matches, so fall back to lane 0
		for (int i = 0; i < `NN_Z; i++)
		begin
			// Later lanes overwrite earlier ones, so the highest match wins
			if (neuron_idx_i[i][`NN_SEL_W-1:0] == MEM_SEL)
			begin
				insert_o = nn_ctrl_pkg::lane_sel_t'(i);
			end
		end
	end

	// In normal operation the interleaver hands out one lane per memory,
	// so at most one compare fires and the priority never matters

endmodule

// ==== address_decoder/address_decoder.sv ====
`include "nn_ctrl_macros.svh"

module address_decoder
(
	input nn_ctrl_pkg::neuron_idx_t [`NN_Z-1:0] neuron_idx_i, // Lane i wants this neuron
	output nn_ctrl_pkg::decode_s decode_o
);

	// For each memory, the lane whose neuron lives in it
	nn_ctrl_pkg::lane_sel_t [`NN_Z-1:0] insert;

	genvar gv_j;
	generate
		for (gv_j = 0; gv_j < `NN_Z; gv_j = gv_j + 1)
		begin: g_mem
			// One search per memory, each with its own memory number
			comparator_set #(
				.MEM_ID(gv_j)
			) comparator_set_i
			(
				.neuron_idx_i(neuron_idx_i),
				.insert_o(insert[gv_j])
			);

			// Memory j reads the entry held in the high bits of the matching lane's index
			assign decode_o.rd_addr[gv_j] =
				neuron_idx_i[insert[gv_j]][`NN_NIDX_W-1 -: `NN_AM_AW];

			// Lane j later picks its value out of the memory named by its low bits
			assign decode_o.mux_sel[gv_j] = neuron_idx_i[gv_j][`NN_SEL_W-1:0];
		end
	endgenerate

	// With a true permutation every memory is claimed by exactly one lane
	// With repeats the highest lane wins and unclaimed memories read via lane 0

endmodule

// ==== rtl/act_mem_ctrl.sv ====
`include "nn_ctrl_macros.svh"

module act_mem_ctrl
(
	input logic clk,
	input logic reset_i,
	input nn_ctrl_pkg::pointer_s pointers_i,
	input nn_ctrl_pkg::cycle_idx_t idx_d2_i, // Index two clocks late, paces the writes
	input nn_ctrl_pkg::decode_s decode_i,
	input logic [`NN_Z/`NN_FO-1:0][`NN_WIDTH-1:0] act_data_i,
	output nn_ctrl_pkg::am_ctrl_s [`NN_COLL-1:0] am_ctrl_o,
	output logic [`NN_Z-1:0][`NN_WIDTH-1:0] act_data_o,
	output nn_ctrl_pkg::lane_sel_t [`NN_Z-1:0] mux_sel_o
);

	// The Z memories split into FO parts, each filled by one clock's data
	localparam int LANES_PER_PART = `NN_Z / `NN_FO;

	nn_ctrl_pkg::am_addr_t wr_addr; // Same entry for every memory of the written collection
	logic [`NN_PART_W-1:0] part_cur; // Part written in this clock
	logic in_window; // Delayed index is still inside the working clocks
	nn_ctrl_pkg::lane_sel_t [`NN_Z-1:0] mux_sel_q;

	// Low bits of the delayed index walk the parts, the rest walk the entries
	assign part_cur = idx_d2_i[`NN_PART_W-1:0];
	assign wr_addr = idx_d2_i[`NN_PART_W +: `NN_AM_AW];
	assign in_window = (idx_d2_i < nn_ctrl_pkg::cycle_idx_t'(`NN_WORK));

	genvar gv_c, gv_p, gv_k, gv_m;
	generate
		for (gv_c = 0; gv_c < `NN_COLL; gv_c = gv_c + 1)
		begin: g_coll
			for (gv_p = 0; gv_p < `NN_FO; gv_p = gv_p + 1)
			begin: g_part
				for (gv_k = 0; gv_k < LANES_PER_PART; gv_k = gv_k + 1)
				begin: g_lane
					// Only the write collection, only the current part, only in the window
					assign am_ctrl_o[gv_c].we[gv_p*LANES_PER_PART + gv_k] = in_window
						&& (int'(part_cur) == gv_p)
						&& (pointers_i.wr == nn_ctrl_pkg::coll_pt_t'(gv_c))
						&& !reset_i;

					// Reads are not destructive, so every other collection follows the decoder
					assign am_ctrl_o[gv_c].addr[gv_p*LANES_PER_PART + gv_k] =
						(pointers_i.wr == nn_ctrl_pkg::coll_pt_t'(gv_c))
						? wr_addr
						: decode_i.rd_addr[gv_p*LANES_PER_PART + gv_k];
				end
			end
		end

		// Each part sees the same group of incoming activations
		// The enables decide which part actually takes it
		for (gv_m = 0; gv_m < `NN_Z; gv_m = gv_m + 1)
		begin: g_data
			assign act_data_o[gv_m] = act_data_i[gv_m % LANES_PER_PART];
		end
	endgenerate

	// Memory data comes out one clock after the address, so the lane muxes wait too
	always_ff @(posedge clk)
	begin
		if (reset_i)
			mux_sel_q <= '0;
		else
			mux_sel_q <= decode_i.mux_sel;
	end

	assign mux_sel_o = mux_sel_q;

endmodule

// ==== rtl/nn_ctrl_top.sv ====
`include "nn_ctrl_macros.svh"

module nn_ctrl_top
(
	input logic clk,
	input logic reset_i,
	input nn_ctrl_pkg::neuron_idx_t [`NN_Z-1:0] neuron_idx_i, // From the external interleaver
	input logic [`NN_Z/`NN_FO-1:0][`NN_WIDTH-1:0] act_data_i, // One part's worth per clock
	output nn_ctrl_pkg::cycle_idx_t cycle_idx_o,
	output nn_ctrl_pkg::am_ctrl_s [`NN_COLL-1:0] am_ctrl_o,
	output logic [`NN_Z-1:0][`NN_WIDTH-1:0] act_data_o, // Write data shared by all collections
	output nn_ctrl_pkg::lane_sel_t [`NN_Z-1:0] mux_sel_o,
	output nn_ctrl_pkg::coll_pt_t rff_pt_o,
	output nn_ctrl_pkg::coll_pt_t rup_pt_o,
	output nn_ctrl_pkg::wm_ctrl_s wm_ctrl_o
);

	nn_ctrl_pkg::timing_s timing; // Index, delayed index and wrap
	nn_ctrl_pkg::pointer_s pointers; // Undelayed collection roles
	nn_ctrl_pkg::decode_s decode; // Raw read addresses and mux selects

	cycle_timer cycle_timer_i
	(
		.clk(clk),
		.reset_i(reset_i),
		.timing_o(timing)
	);

	assign cycle_idx_o = timing.idx; // Undelayed index goes straight out

	input_layer_state_machine input_layer_state_machine_i
	(
		.clk(clk),
		.reset_i(reset_i),
		.timing_i(timing),
		.pointers_o(pointers),
		.rff_pt_o(rff_pt_o),
		.rup_pt_o(rup_pt_o),
		.wm_ctrl_o(wm_ctrl_o)
	);

	address_decoder address_decoder_i
	(
		.neuron_idx_i(neuron_idx_i),
		.decode_o(decode)
	);

	act_mem_ctrl act_mem_ctrl_i
	(
		.clk(clk),
		.reset_i(reset_i),
		.pointers_i(pointers),
		.idx_d2_i(timing.idx_d2), // Writes trail the read pipeline by two clocks
		.decode_i(decode),
		.act_data_i(act_data_i),
		.am_ctrl_o(am_ctrl_o),
		.act_data_o(act_data_o),
		.mux_sel_o(mux_sel_o)
	);

endmodule

// ==== dv/nn_ctrl_ref.svh ====
`ifndef NN_CTRL_REF_SVH
`define NN_CTRL_REF_SVH

// Every function takes k as the number of rising edges seen since reset was released

function automatic nn_ctrl_pkg::cycle_idx_t cycle_position(input int k);
	return nn_ctrl_pkg::cycle_idx_t'(k % `NN_CPC); // Counts 0..CPC-1 and starts over
endfunction

// Index as it stood two clocks ago and 0 until two clocks have passed
function automatic nn_ctrl_pkg::cycle_idx_t delayed_position(input int k);
	if (k < 2)
		return '0;
	return nn_ctrl_pkg::cycle_idx_t'((k - 2) % `NN_CPC);
endfunction

// One wrap per full junction cycle, so a role moves k/CPC steps from where it started
function automatic nn_ctrl_pkg::coll_pt_t rotated_pointer(input int k, input int start);
	return nn_ctrl_pkg::coll_pt_t'((start + k / `NN_CPC) % `NN_COLL);
endfunction

function automatic nn_ctrl_pkg::coll_pt_t lagged_pointer(input int k, input int start);
	if (k == 0)
		return '0; // Output copies come out of reset at 0
	return rotated_pointer(k - 1, start); // One clock behind the internal pointer
endfunction

function automatic nn_ctrl_pkg::wm_ctrl_s weight_mem_ctrl(input int k, input logic rst);
	nn_ctrl_pkg::wm_ctrl_s w;
	int idx;
	idx = k % `NN_CPC;
	w.we_b = !rst && (idx > 0) && (idx <= `NN_WORK); // Only the working clocks write
	w.rd_addr = nn_ctrl_pkg::wm_addr_t'(idx % (1 << `NN_WM_AW));
	w.wr_addr = (k == 0) ? '0 : nn_ctrl_pkg::wm_addr_t'(((k - 1) % `NN_CPC) % (1 << `NN_WM_AW));
	return w;
endfunction

// Scan from the top lane down so the first hit is the highest one
function automatic nn_ctrl_pkg::am_addr_t highest_lane_addr(
	input nn_ctrl_pkg::neuron_idx_t [`NN_Z-1:0] nidx, input int mem);
	for (int i = `NN_Z - 1; i >= 0; i--)
	begin
		if (nidx[i] % `NN_Z == mem)
			return nn_ctrl_pkg::am_addr_t'(nidx[i] / `NN_Z); // Entry lives in the high bits
	end
	return nn_ctrl_pkg::am_addr_t'(nidx[0] / `NN_Z); // No lane claims it so lane 0 stands in
endfunction

function automatic nn_ctrl_pkg::am_ctrl_s collection_ctrl(input int c, input int k,
	input logic rst, input nn_ctrl_pkg::neuron_idx_t [`NN_Z-1:0] nidx);
	nn_ctrl_pkg::am_ctrl_s a;
	int d2;
	int lanes;
	logic is_wr;
	d2 = delayed_position(k);
	lanes = `NN_Z / `NN_FO;
	is_wr = (c == rotated_pointer(k, 1)); // Write role starts on collection 1
	for (int j = 0; j < `NN_Z; j++)
	begin
		a.we[j] = !rst && is_wr && (d2 < `NN_WORK) && (j / lanes == d2 % `NN_FO);
		if (is_wr)
			a.addr[j] = nn_ctrl_pkg::am_addr_t'((d2 / `NN_FO) % (`NN_P / `NN_Z));
		else
			a.addr[j] = highest_lane_addr(nidx, j);
	end
	return a;
endfunction

function automatic logic [`NN_Z-1:0][`NN_WIDTH-1:0] spread_data(
	input logic [`NN_Z/`NN_FO-1:0][`NN_WIDTH-1:0] din);
	logic [`NN_Z-1:0][`NN_WIDTH-1:0] d;
	for (int m = 0; m < `NN_Z; m++)
		d[m] = din[m % (`NN_Z / `NN_FO)]; // Every part carries the same group
	return d;
endfunction

// Lane select is the memory number of the index one clock earlier
function automatic nn_ctrl_pkg::lane_sel_t registered_sel(input int k,
	input nn_ctrl_pkg::neuron_idx_t [`NN_Z-1:0] prev, input int lane);
	if (k == 0)
		return '0;
	return nn_ctrl_pkg::lane_sel_t'(prev[lane] % `NN_Z);
endfunction

`endif

// ==== dv/nn_ctrl_tb.sv ====
`include "nn_ctrl_macros.svh"

module nn_ctrl_tb;

	localparam int PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int RUN_CYCLES = 60; // Junction cycles after reset

	logic clk;
	logic reset_i;
	nn_ctrl_pkg::neuron_idx_t [`NN_Z-1:0] neuron_idx_i;
	logic [`NN_Z/`NN_FO-1:0][`NN_WIDTH-1:0] act_data_i;
	nn_ctrl_pkg::cycle_idx_t cycle_idx_o;
	nn_ctrl_pkg::am_ctrl_s [`NN_COLL-1:0] am_ctrl_o;
	logic [`NN_Z-1:0][`NN_WIDTH-1:0] act_data_o;
	nn_ctrl_pkg::lane_sel_t [`NN_Z-1:0] mux_sel_o;
	nn_ctrl_pkg::coll_pt_t rff_pt_o;
	nn_ctrl_pkg::coll_pt_t rup_pt_o;
	nn_ctrl_pkg::wm_ctrl_s wm_ctrl_o;

	logic [31:0] lfsr; // Random source for all stimulus
	int stim_cnt; // Clocks driven so far
	int clk_cnt; // Rising edges since reset was released
	nn_ctrl_pkg::neuron_idx_t [`NN_Z-1:0] prev_nidx; // Indices seen at the last rising edge
	int checks;
	int errors;

	`include "nn_ctrl_ref.svh"

	nn_ctrl_top nn_ctrl_top_i
	(
		.clk(clk),
		.reset_i(reset_i),
		.neuron_idx_i(neuron_idx_i),
		.act_data_i(act_data_i),
		.cycle_idx_o(cycle_idx_o),
		.am_ctrl_o(am_ctrl_o),
		.act_data_o(act_data_o),
		.mux_sel_o(mux_sel_o),
		.rff_pt_o(rff_pt_o),
		.rup_pt_o(rup_pt_o),
		.wm_ctrl_o(wm_ctrl_o)
	);

	// Taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit handed out
	task automatic draw_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		int j;
		nn_ctrl_pkg::lane_sel_t tmp;
		nn_ctrl_pkg::lane_sel_t [`NN_Z-1:0] perm;
		for (int i = 0; i < `NN_Z; i++)
		begin
			draw_bits(`NN_NIDX_W, r);
			neuron_idx_i[i] = nn_ctrl_pkg::neuron_idx_t'(r);
		end
		if (stim_cnt % 10 == 9)
		begin
			// Shuffle 0..Z-1 so every memory is claimed by exactly one lane
			for (int i = 0; i < `NN_Z; i++)
				perm[i] = nn_ctrl_pkg::lane_sel_t'(i);
			for (int i = `NN_Z - 1; i > 0; i--)
			begin
				draw_bits(8, r);
				j = r % (i + 1);
				tmp = perm[i];
				perm[i] = perm[j];
				perm[j] = tmp;
			end
			for (int i = 0; i < `NN_Z; i++)
				neuron_idx_i[i][`NN_SEL_W-1:0] = perm[i]; // High bits stay random
		end
		for (int g = 0; g < `NN_Z / `NN_FO; g++)
		begin
			draw_bits(`NN_WIDTH, r);
			act_data_i[g] = r[`NN_WIDTH-1:0];
		end
		stim_cnt++;
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] exp_val,
		input logic [127:0] act_val);
		errors++;
		$display("Error at time %0t: %s expected %0h, got %0h", $time, name, exp_val, act_val);
	endtask

	task automatic print_summary();
		$display("Clocks checked: %0d, errors: %0d", checks, errors);
	endtask

	task automatic check_outputs();
		nn_ctrl_pkg::cycle_idx_t exp_idx;
		nn_ctrl_pkg::coll_pt_t exp_rff;
		nn_ctrl_pkg::coll_pt_t exp_rup;
		nn_ctrl_pkg::wm_ctrl_s exp_wm;
		nn_ctrl_pkg::am_ctrl_s exp_am;
		nn_ctrl_pkg::lane_sel_t exp_sel;
		logic [`NN_Z-1:0][`NN_WIDTH-1:0] exp_data;
		checks++;
		exp_idx = cycle_position(clk_cnt); // Count stays 0 through reset
		exp_rff = lagged_pointer(clk_cnt, 0);
		exp_rup = lagged_pointer(clk_cnt, 2);
		exp_wm = weight_mem_ctrl(clk_cnt, reset_i);
		exp_data = spread_data(act_data_i);
		if (cycle_idx_o !== exp_idx)
			report_mismatch("cycle_idx_o", exp_idx, cycle_idx_o);
		if (rff_pt_o !== exp_rff)
			report_mismatch("rff_pt_o", exp_rff, rff_pt_o);
		if (rup_pt_o !== exp_rup)
			report_mismatch("rup_pt_o", exp_rup, rup_pt_o);
		if (wm_ctrl_o !== exp_wm)
			report_mismatch("wm_ctrl_o", exp_wm, wm_ctrl_o);
		if (act_data_o !== exp_data)
			report_mismatch("act_data_o", exp_data, act_data_o);
		for (int c = 0; c < `NN_COLL; c++)
		begin
			exp_am = collection_ctrl(c, clk_cnt, reset_i, neuron_idx_i);
			if (am_ctrl_o[c] !== exp_am)
				report_mismatch($sformatf("am_ctrl_o[%0d]", c), exp_am, am_ctrl_o[c]);
		end
		for (int m = 0; m < `NN_Z; m++)
		begin
			exp_sel = registered_sel(clk_cnt, prev_nidx, m);
			if (mux_sel_o[m] !== exp_sel)
				report_mismatch($sformatf("mux_sel_o[%0d]", m), exp_sel, mux_sel_o[m]);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	// Stimulus changes on the falling edge only
	initial
	begin
		lfsr = 32'h6789f61d;
		stim_cnt = 0;
		reset_i = 1'b1;
		neuron_idx_i = '0;
		act_data_i = '0;
		repeat (RESET_CYCLES)
		begin
			@(negedge clk);
			drive_inputs();
		end
		reset_i = 1'b0;
		repeat (RUN_CYCLES * `NN_CPC)
		begin
			@(negedge clk);
			drive_inputs();
		end
		@(negedge clk);
		#(PERIOD / 2 - 10); // Let the last compare finish
		print_summary();
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Compare a quarter period after the falling edge and well before the next rising edge
	initial
	begin
		clk_cnt = 0;
		checks = 0;
		errors = 0;
		prev_nidx = '0;
		forever
		begin
			@(negedge clk);
			#(PERIOD / 4);
			check_outputs();
			prev_nidx = neuron_idx_i; // These are what the coming edge registers
			if (!reset_i)
				clk_cnt++;
		end
	end

	initial
	begin
		#((RESET_CYCLES + RUN_CYCLES * `NN_CPC + 20) * PERIOD);
		$display("Timeout: the run did not reach its end in the expected number of clocks");
		print_summary();
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+common
+incdir+dv
common/nn_ctrl_pkg.sv
rtl/cycle_timer.sv
rtl/input_layer_state_machine.sv
address_decoder/comparator_set.sv
address_decoder/address_decoder.sv
rtl/act_mem_ctrl.sv
rtl/nn_ctrl_top.sv
dv/nn_ctrl_tb.sv
